// File: Bender.yml
package:
  name: conv_core

export_include_dirs:
  - design

sources:
  - files:
      - design/conv_pkg.sv
      - design/pix_bus_if.sv
      - design/feature_ram.sv
      - design/layer_ctrl.sv
      - design/window_scan.sv
      - design/conv_mac.sv
      - design/output_writer.sv
      - design/conv_core_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_conv_core.sv

// File: design/conv_core_top.sv
`include "conv_defines.svh"

module conv_core_top
  import conv_pkg::*;
(
  input  logic                clk,
  input  logic                xrst,
  input  logic                req,
  output logic                ack,
  output layer_state_t        core_state,
  input  logic [`LWIDTH-1:0]  total_in,
  input  logic [`LWIDTH-1:0]  total_out,
  input  logic [`LWIDTH-1:0]  img_size,
  input  logic [`LWIDTH-1:0]  conv_size,
  input  logic [`LWIDTH-1:0]  conv_pad,
  input  logic [`IMGSIZE-1:0] in_offset,
  input  logic [`IMGSIZE-1:0] out_offset,
  input  logic [`NETSIZE-1:0] net_offset,
  input  logic                host_img_we,
  input  logic [`IMGSIZE-1:0] host_img_addr,
  input  data_t               host_img_wdata,
  input  logic [`IMGSIZE-1:0] host_raddr,
  output data_t               host_rdata,
  input  logic                host_net_we,
  input  logic [`NETSIZE-1:0] host_net_addr,
  input  data_t               host_net_wdata
);

  logic [`LWIDTH-1:0]  w_img_size;
  logic [`LWIDTH-1:0]  w_conv_size;
  logic [`LWIDTH-1:0]  w_conv_pad;
  logic [`LWIDTH-1:0]  w_fea_size;
  logic [`NETSIZE-1:0] net_raddr;
  data_t               net_rdata;
  logic                wreg_we;
  logic                breg_we;
  logic [`WIDX-1:0]    weight_idx;
  logic                first_input;
  logic                last_input;
  logic                scan_req;
  logic                scan_end;
  logic                out_req;
  logic                out_end;
  logic [`LWIDTH-1:0]  in_count;
  logic [`LWIDTH-1:0]  out_count;
  logic [`IMGSIZE-1:0] img_raddr;
  logic [`OUTSIZE-1:0] psum_raddr;
  acc_t                psum_rdata;
  logic                img_we;
  logic [`IMGSIZE-1:0] img_waddr;
  data_t               img_wdata;

  pix_bus_if pix_bus ();

  // ========================================
  // pipeline stages
  // ========================================

  layer_ctrl u_ctrl (
    .clk         (clk),
    .xrst        (xrst),
    .req         (req),
    .total_in    (total_in),
    .total_out   (total_out),
    .img_size    (img_size),
    .conv_size   (conv_size),
    .conv_pad    (conv_pad),
    .net_offset  (net_offset),
    .ack         (ack),
    .core_state  (core_state),
    .w_img_size  (w_img_size),
    .w_conv_size (w_conv_size),
    .w_conv_pad  (w_conv_pad),
    .w_fea_size  (w_fea_size),
    .net_raddr   (net_raddr),
    .wreg_we     (wreg_we),
    .breg_we     (breg_we),
    .weight_idx  (weight_idx),
    .first_input (first_input),
    .last_input  (last_input),
    .scan_req    (scan_req),
    .out_req     (out_req),
    .in_count    (in_count),
    .out_count   (out_count),
    .scan_end    (scan_end),
    .out_end     (out_end)
  );

  window_scan u_scan (
    .clk        (clk),
    .xrst       (xrst),
    .scan_req   (scan_req),
    .img_size   (w_img_size),
    .conv_size  (w_conv_size),
    .conv_pad   (w_conv_pad),
    .fea_size   (w_fea_size),
    .in_offset  (in_offset),
    .in_count   (in_count),
    .scan_end   (scan_end),
    .img_raddr  (img_raddr),
    .img_rdata  (host_rdata),
    .host_raddr (host_raddr),
    .pix        (pix_bus.master)
  );

  conv_mac u_mac (
    .clk         (clk),
    .xrst        (xrst),
    .net_rdata   (net_rdata),
    .wreg_we     (wreg_we),
    .breg_we     (breg_we),
    .weight_idx  (weight_idx),
    .first_input (first_input),
    .last_input  (last_input),
    .pix         (pix_bus.slave),
    .psum_raddr  (psum_raddr),
    .psum_rdata  (psum_rdata)
  );

  output_writer u_out (
    .clk        (clk),
    .xrst       (xrst),
    .out_req    (out_req),
    .out_offset (out_offset),
    .fea_size   (w_fea_size),
    .out_count  (out_count),
    .host_we    (host_img_we),
    .host_waddr (host_img_addr),
    .host_wdata (host_img_wdata),
    .ack        (ack),
    .psum_raddr (psum_raddr),
    .out_end    (out_end),
    .img_we     (img_we),
    .img_waddr  (img_waddr),
    .img_wdata  (img_wdata),
    .psum_rdata (psum_rdata)
  );

  // ========================================
  // memories
  // ========================================

  feature_ram #(.DEPTH_LOG(`IMGSIZE), .WIDTH(`DWIDTH)) u_img_ram (
    .clk   (clk),
    .we    (img_we),
    .waddr (img_waddr),
    .wdata (img_wdata),
    .raddr (img_raddr),
    .rdata (host_rdata)
  );

  feature_ram #(.DEPTH_LOG(`NETSIZE), .WIDTH(`DWIDTH)) u_net_ram (
    .clk   (clk),
    .we    (host_net_we),
    .waddr (host_net_addr),
    .wdata (host_net_wdata),
    .raddr (net_raddr),
    .rdata (net_rdata)
  );

endmodule

// File: design/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// ========================================
// data widths
// ========================================

// signed pixel, weight and bias word
`define DWIDTH 16
// accumulator, wide enough for a full window over many maps
`define AWIDTH 40
// layer shape fields
`define LWIDTH 8

// ========================================
// memory address widths
// ========================================

`define IMGSIZE 12
`define NETSIZE 10
// partial sums, one entry per feature position
`define OUTSIZE 8

// weight register file, filters up to 3x3
`define WNUM 9
`define WIDX 4

`endif

// File: design/conv_mac.sv
`include "conv_defines.svh"

module conv_mac
  import conv_pkg::*;
(
  input  logic                clk,
  input  logic                xrst,
  input  data_t               net_rdata,
  input  logic                wreg_we,
  input  logic                breg_we,
  input  logic [`WIDX-1:0]    weight_idx,
  input  logic                first_input,
  input  logic                last_input,
  pix_bus_if.slave            pix,
  input  logic [`OUTSIZE-1:0] psum_raddr,
  output acc_t                psum_rdata
);

  data_t               wreg [`WNUM];
  data_t               bias;
  weight_phase_t       wphase;
  logic [`WIDX-1:0]    tap;
  logic [`WIDX-1:0]    tap_sel;
  acc_t                prod;
  acc_t                acc;
  acc_t                psum [2**`OUTSIZE];
  logic [`OUTSIZE-1:0] pos;
  logic                sum_we;

  // ========================================
  // parameter registers
  // ========================================

  assign wphase = breg_we ? S_W_BIAS : S_W_WEIGHT;

  always_ff @(posedge clk) begin
    if (wreg_we || breg_we) begin
      case (wphase)
        S_W_WEIGHT: wreg[weight_idx] <= net_rdata;
        S_W_BIAS:   bias <= net_rdata;
      endcase
    end
  end

  // ========================================
  // multiply-accumulate
  // ========================================

  assign tap_sel = pix.start ? '0 : tap;
  assign prod    = acc_t'(pix.pix) * acc_t'(wreg[tap_sel]);

  always_ff @(posedge clk) begin
    if (pix.valid) begin
      acc <= (pix.start ? '0 : acc) + prod;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      tap    <= '0;
      sum_we <= 1'b0;
      pos    <= '0;
    end else begin
      sum_we <= pix.valid && pix.stop;
      if (pix.valid) begin
        tap <= tap_sel + 1'b1;
      end
      // a weight load comes before every scan
      if (wreg_we) begin
        pos <= '0;
      end else if (sum_we) begin
        pos <= pos + 1'b1;
      end
    end
  end

  // window total merged into the partial sum
  always_ff @(posedge clk) begin
    if (sum_we) begin
      psum[pos] <= acc + (first_input ? '0 : psum[pos]) + (last_input ? acc_t'(bias) : '0);
    end
    psum_rdata <= psum[psum_raddr];
  end

endmodule

// File: design/conv_pkg.sv
`include "conv_defines.svh"

package conv_pkg;

  // ========================================
  // control states
  // ========================================

  // layer sequencer
  typedef enum logic [1:0] {
    S_WAIT    = 2'd0,
    S_NETWORK = 2'd1,
    S_INPUT   = 2'd2,
    S_OUTPUT  = 2'd3
  } layer_state_t;

  // which parameter the net memory word goes to
  typedef enum logic {
    S_W_WEIGHT = 1'b0,
    S_W_BIAS   = 1'b1
  } weight_phase_t;

  // ========================================
  // arithmetic types
  // ========================================

  typedef logic signed [`DWIDTH-1:0] data_t;
  typedef logic signed [`AWIDTH-1:0] acc_t;

endpackage

// File: design/feature_ram.sv
module feature_ram #(
  parameter int DEPTH_LOG = 12,
  parameter int WIDTH     = 16
) (
  input  logic                 clk,
  input  logic                 we,
  input  logic [DEPTH_LOG-1:0] waddr,
  input  logic [WIDTH-1:0]     wdata,
  input  logic [DEPTH_LOG-1:0] raddr,
  output logic [WIDTH-1:0]     rdata
);

  logic [WIDTH-1:0] mem [2**DEPTH_LOG];

  // one cycle read latency
  always_ff @(posedge clk) begin
    if (we) mem[waddr] <= wdata;
    rdata <= mem[raddr];
  end

endmodule

// File: design/layer_ctrl.sv
`include "conv_defines.svh"

module layer_ctrl
  import conv_pkg::*;
(
  input  logic                clk,
  input  logic                xrst,
  input  logic                req,
  input  logic [`LWIDTH-1:0]  total_in,
  input  logic [`LWIDTH-1:0]  total_out,
  input  logic [`LWIDTH-1:0]  img_size,
  input  logic [`LWIDTH-1:0]  conv_size,
  input  logic [`LWIDTH-1:0]  conv_pad,
  input  logic [`NETSIZE-1:0] net_offset,
  output logic                ack,
  output layer_state_t        core_state,
  output logic [`LWIDTH-1:0]  w_img_size,
  output logic [`LWIDTH-1:0]  w_conv_size,
  output logic [`LWIDTH-1:0]  w_conv_pad,
  output logic [`LWIDTH-1:0]  w_fea_size,
  output logic [`NETSIZE-1:0] net_raddr,
  output logic                wreg_we,
  output logic                breg_we,
  output logic [`WIDX-1:0]    weight_idx,
  output logic                first_input,
  output logic                last_input,
  output logic                scan_req,
  output logic                out_req,
  output logic [`LWIDTH-1:0]  in_count,
  output logic [`LWIDTH-1:0]  out_count,
  input  logic                scan_end,
  input  logic                out_end
);

  layer_state_t        state;
  weight_phase_t       wphase;
  logic                req_d;
  logic                req_edge;
  logic                last_in;
  logic                last_out;
  logic                weight_end;
  logic                bias_end;
  logic                network_end;
  logic [`LWIDTH-1:0]  total_in_r;
  logic [`LWIDTH-1:0]  total_out_r;
  logic [`WIDX-1:0]    n_taps;
  logic [`WIDX-1:0]    widx;

  // ========================================
  // layer sequencer
  // ========================================

  assign req_edge   = req && !req_d;
  assign last_in    = in_count == total_in_r - 1'b1;
  assign last_out   = out_count == total_out_r - 1'b1;
  assign core_state = state;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_d <= 1'b0;
    end else begin
      req_d <= req;
    end
  end

  // main FSM, inputs inside outputs
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= S_WAIT;
      in_count  <= '0;
      out_count <= '0;
    end else begin
      case (state)
        S_WAIT:
          if (req_edge) state <= S_NETWORK;
        S_NETWORK:
          if (network_end) state <= S_INPUT;
        S_INPUT:
          if (scan_end) begin
            if (last_in) begin
              state    <= S_OUTPUT;
              in_count <= '0;
            end else begin
              state    <= S_NETWORK;
              in_count <= in_count + 1'b1;
            end
          end
        S_OUTPUT:
          if (out_end) begin
            if (last_out) begin
              state     <= S_WAIT;
              out_count <= '0;
            end else begin
              state     <= S_NETWORK;
              out_count <= out_count + 1'b1;
            end
          end
        default:
          state <= S_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack <= 1'b1;
    end else if (state == S_WAIT && req_edge) begin
      ack <= 1'b0;
    end else if (state == S_OUTPUT && out_end && last_out) begin
      ack <= 1'b1;
    end
  end

  // shape is taken on the starting edge only
  always_ff @(posedge clk) begin
    if (!xrst) begin
      total_in_r  <= '0;
      total_out_r <= '0;
      w_img_size  <= '0;
      w_conv_size <= '0;
      w_conv_pad  <= '0;
      w_fea_size  <= '0;
    end else if (state == S_WAIT && req_edge) begin
      total_in_r  <= total_in;
      total_out_r <= total_out;
      w_img_size  <= img_size;
      w_conv_size <= conv_size;
      w_conv_pad  <= conv_pad;
      w_fea_size  <= img_size + (conv_pad << 1) - conv_size + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      first_input <= 1'b0;
      last_input  <= 1'b0;
    end else begin
      first_input <= state == S_INPUT && in_count == '0;
      last_input  <= state == S_INPUT && last_in;
    end
  end

  // ========================================
  // weight loader
  // ========================================

  assign n_taps      = `WIDX'(w_conv_size * w_conv_size);
  assign weight_end  = state == S_NETWORK && wphase == S_W_WEIGHT && widx == n_taps - 1'b1;
  assign bias_end    = state == S_NETWORK && wphase == S_W_BIAS;
  // bias follows the weights of the last input map only
  assign network_end = last_in ? bias_end : weight_end;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wphase <= S_W_WEIGHT;
    end else begin
      case (wphase)
        S_W_WEIGHT:
          if (weight_end && last_in) wphase <= S_W_BIAS;
        S_W_BIAS:
          if (bias_end) wphase <= S_W_WEIGHT;
        default:
          wphase <= S_W_WEIGHT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      widx <= '0;
    end else if (state == S_NETWORK && wphase == S_W_WEIGHT && !weight_end) begin
      widx <= widx + 1'b1;
    end else begin
      widx <= '0;
    end
  end

  // net address keeps running, so maps and bias sit back to back
  always_ff @(posedge clk) begin
    if (!xrst) begin
      net_raddr <= '0;
    end else if (state == S_WAIT && req_edge) begin
      net_raddr <= net_offset;
    end else if (state == S_NETWORK) begin
      net_raddr <= net_raddr + 1'b1;
    end
  end

  // write strobes land with the RAM read data
  always_ff @(posedge clk) begin
    if (!xrst) begin
      wreg_we    <= 1'b0;
      breg_we    <= 1'b0;
      weight_idx <= '0;
      scan_req   <= 1'b0;
      out_req    <= 1'b0;
    end else begin
      wreg_we    <= state == S_NETWORK && wphase == S_W_WEIGHT;
      breg_we    <= state == S_NETWORK && wphase == S_W_BIAS;
      weight_idx <= widx;
      scan_req   <= network_end;
      out_req    <= state == S_INPUT && scan_end && last_in;
    end
  end

endmodule

// File: design/output_writer.sv
`include "conv_defines.svh"

module output_writer
  import conv_pkg::*;
(
  input  logic                clk,
  input  logic                xrst,
  input  logic                out_req,
  input  logic [`IMGSIZE-1:0] out_offset,
  input  logic [`LWIDTH-1:0]  fea_size,
  input  logic [`LWIDTH-1:0]  out_count,
  input  logic                host_we,
  input  logic [`IMGSIZE-1:0] host_waddr,
  input  data_t               host_wdata,
  input  logic                ack,
  output logic [`OUTSIZE-1:0] psum_raddr,
  output logic                out_end,
  output logic                img_we,
  output logic [`IMGSIZE-1:0] img_waddr,
  output data_t               img_wdata,
  input  acc_t                psum_rdata
);

  localparam acc_t SAT_MAX = acc_t'(2**(`DWIDTH-1) - 1);
  localparam acc_t SAT_MIN = -acc_t'(2**(`DWIDTH-1));

  layer_state_t          mode;
  logic [2*`LWIDTH-1:0]  n_pos;
  logic                  rd_last;
  logic                  wr_valid;
  logic [`OUTSIZE-1:0]   wr_pos;
  logic [`IMGSIZE-1:0]   out_offset_r;
  logic [`IMGSIZE-1:0]   base;
  data_t                 sat;

  assign n_pos   = fea_size * fea_size;
  assign rd_last = psum_raddr == n_pos[`OUTSIZE-1:0] - 1'b1;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      mode       <= S_WAIT;
      psum_raddr <= '0;
      wr_valid   <= 1'b0;
      out_end    <= 1'b0;
    end else begin
      wr_valid <= mode == S_OUTPUT;
      out_end  <= mode == S_OUTPUT && rd_last;
      if (out_req) begin
        mode       <= S_OUTPUT;
        psum_raddr <= '0;
      end else if (mode == S_OUTPUT) begin
        if (rd_last) mode <= S_WAIT;
        psum_raddr <= psum_raddr + 1'b1;
      end
    end
  end

  // offset held from the idle period, map base fixed per output map
  always_ff @(posedge clk) begin
    if (ack) out_offset_r <= out_offset;
    if (out_req) base <= out_offset_r + `IMGSIZE'(out_count) * `IMGSIZE'(n_pos);
    wr_pos <= psum_raddr;
  end

  // clip to the 16-bit range
  assign sat = psum_rdata > SAT_MAX ? data_t'(SAT_MAX)
             : psum_rdata < SAT_MIN ? data_t'(SAT_MIN)
             : data_t'(psum_rdata);

  // host owns the write port while idle
  assign img_we    = ack ? host_we : wr_valid;
  assign img_waddr = ack ? host_waddr : base + `IMGSIZE'(wr_pos);
  assign img_wdata = ack ? host_wdata : sat;

endmodule

// File: design/pix_bus_if.sv
`include "conv_defines.svh"

interface pix_bus_if
  import conv_pkg::*;
();

  // one pixel per cycle, no back-pressure
  logic  start;
  logic  valid;
  logic  stop;
  data_t pix;

  modport master (
    output start, valid, stop, pix
  );

  modport slave (
    input start, valid, stop, pix
  );

endinterface

// File: design/window_scan.sv
`include "conv_defines.svh"

module window_scan
  import conv_pkg::*;
(
  input  logic                clk,
  input  logic                xrst,
  input  logic                scan_req,
  input  logic [`LWIDTH-1:0]  img_size,
  input  logic [`LWIDTH-1:0]  conv_size,
  input  logic [`LWIDTH-1:0]  conv_pad,
  input  logic [`LWIDTH-1:0]  fea_size,
  input  logic [`IMGSIZE-1:0] in_offset,
  input  logic [`LWIDTH-1:0]  in_count,
  output logic                scan_end,
  output logic [`IMGSIZE-1:0] img_raddr,
  input  data_t               img_rdata,
  input  logic [`IMGSIZE-1:0] host_raddr,
  pix_bus_if.master           pix
);

  logic                      busy;
  logic [`LWIDTH-1:0]        fx;
  logic [`LWIDTH-1:0]        fy;
  logic [`LWIDTH-1:0]        wx;
  logic [`LWIDTH-1:0]        wy;
  logic signed [`LWIDTH+1:0] row;
  logic signed [`LWIDTH+1:0] col;
  logic                      is_pad;
  logic                      win_last;
  logic                      map_last;
  logic [`IMGSIZE-1:0]       base;
  logic                      valid_d;
  logic                      start_d;
  logic                      stop_d;
  logic                      pad_d;
  logic                      last_d;

  // position in the unpadded image, negative inside the border
  assign row = $signed({2'b00, fy}) + $signed({2'b00, wy}) - $signed({2'b00, conv_pad});
  assign col = $signed({2'b00, fx}) + $signed({2'b00, wx}) - $signed({2'b00, conv_pad});

  assign is_pad = row < 0 || col < 0
               || row >= $signed({2'b00, img_size})
               || col >= $signed({2'b00, img_size});

  assign win_last = wx == conv_size - 1'b1 && wy == conv_size - 1'b1;
  assign map_last = fx == fea_size - 1'b1 && fy == fea_size - 1'b1;

  // host reads results through the same port while idle
  assign img_raddr = busy
                   ? base + `IMGSIZE'(row[`LWIDTH-1:0]) * `IMGSIZE'(img_size)
                          + `IMGSIZE'(col[`LWIDTH-1:0])
                   : host_raddr;

  always_ff @(posedge clk) begin
    if (scan_req) begin
      base <= in_offset + `IMGSIZE'(in_count) * `IMGSIZE'(img_size) * `IMGSIZE'(img_size);
    end
  end

  // ========================================
  // position counters
  // ========================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      busy <= 1'b0;
      fx   <= '0;
      fy   <= '0;
      wx   <= '0;
      wy   <= '0;
    end else if (scan_req) begin
      busy <= 1'b1;
      fx   <= '0;
      fy   <= '0;
      wx   <= '0;
      wy   <= '0;
    end else if (busy) begin
      if (wx == conv_size - 1'b1) begin
        wx <= '0;
        if (wy == conv_size - 1'b1) begin
          wy <= '0;
          if (fx == fea_size - 1'b1) begin
            fx <= '0;
            if (fy == fea_size - 1'b1) begin
              fy   <= '0;
              busy <= 1'b0;
            end else begin
              fy <= fy + 1'b1;
            end
          end else begin
            fx <= fx + 1'b1;
          end
        end else begin
          wy <= wy + 1'b1;
        end
      end else begin
        wx <= wx + 1'b1;
      end
    end
  end

  // ========================================
  // pixel stream
  // ========================================

  // strobes delayed to match the RAM read latency
  always_ff @(posedge clk) begin
    if (!xrst) begin
      valid_d  <= 1'b0;
      start_d  <= 1'b0;
      stop_d   <= 1'b0;
      pad_d    <= 1'b0;
      last_d   <= 1'b0;
      scan_end <= 1'b0;
    end else begin
      valid_d  <= busy;
      start_d  <= busy && wx == '0 && wy == '0;
      stop_d   <= busy && win_last;
      pad_d    <= is_pad;
      last_d   <= busy && win_last && map_last;
      // lines up with the last partial-sum write
      scan_end <= last_d;
    end
  end

  assign pix.start = start_d;
  assign pix.valid = valid_d;
  assign pix.stop  = stop_d;
  assign pix.pix   = pad_d ? '0 : img_rdata;

endmodule

// File: src.f
+incdir+design
design/conv_pkg.sv
design/pix_bus_if.sv
design/feature_ram.sv
design/layer_ctrl.sv
design/window_scan.sv
design/conv_mac.sv
design/output_writer.sv
design/conv_core_top.sv
test/tb_clock_gen.sv
test/tb_conv_core.sv

// File: test/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic xrst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // release lands 1 ns after an edge, like the other stimulus
  initial begin
    xrst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    xrst = 1'b1;
  end

endmodule

// File: test/tb_conv_core.sv
module tb_conv_core
  import conv_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic         clk;
  logic         xrst;
  logic         req;
  logic         ack;
  layer_state_t core_state;
  logic [7:0]   total_in;
  logic [7:0]   total_out;
  logic [7:0]   img_size;
  logic [7:0]   conv_size;
  logic [7:0]   conv_pad;
  logic [11:0]  in_offset;
  logic [11:0]  out_offset;
  logic [9:0]   net_offset;
  logic         host_img_we;
  logic [11:0]  host_img_addr;
  data_t        host_img_wdata;
  logic [11:0]  host_raddr;
  data_t        host_rdata;
  logic         host_net_we;
  logic [9:0]   host_net_addr;
  data_t        host_net_wdata;

  // host-side copies of both memories for the reference model
  data_t        img_model [4096];
  data_t        net_model [1024];

  logic [31:0]  rng_state;
  int           n_checks;
  int           n_errors;
  int           mark_checks;
  int           mark_errors;
  bit           hung;
  int           cfg_in;
  int           cfg_out;
  int           cfg_size;
  int           cfg_k;
  int           cfg_pad;
  int           cfg_in_off;
  int           cfg_out_off;
  int           cfg_net_off;

  tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(8)) u_clk (
    .clk  (clk),
    .xrst (xrst)
  );

  conv_core_top uut (
    .clk            (clk),
    .xrst           (xrst),
    .req            (req),
    .ack            (ack),
    .core_state     (core_state),
    .total_in       (total_in),
    .total_out      (total_out),
    .img_size       (img_size),
    .conv_size      (conv_size),
    .conv_pad       (conv_pad),
    .in_offset      (in_offset),
    .out_offset     (out_offset),
    .net_offset     (net_offset),
    .host_img_we    (host_img_we),
    .host_img_addr  (host_img_addr),
    .host_img_wdata (host_img_wdata),
    .host_raddr     (host_raddr),
    .host_rdata     (host_rdata),
    .host_net_we    (host_net_we),
    .host_net_addr  (host_net_addr),
    .host_net_wdata (host_net_wdata)
  );

  // ========================================
  // random values and reference model
  // ========================================

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // -7 .. 7
  function automatic data_t small_value();
    return data_t'(int'(xorshift32() % 32'd15) - 7);
  endfunction

  // magnitude 0x4000 .. 0x7fff
  function automatic data_t large_value(input bit negative);
    data_t v;
    v = data_t'(32'h4000 | (xorshift32() & 32'h3fff));
    return negative ? -v : v;
  endfunction

  function automatic int fea_size();
    return cfg_size + 2 * cfg_pad - cfg_k + 1;
  endfunction

  // zero-padded convolution summed over the input maps plus bias and clipped to 16 bits
  function automatic data_t expected_out(input int o, input int fy, input int fx);
    longint sum;
    int     wbase;
    int     i;
    int     ky;
    int     kx;
    int     r;
    int     c;
    sum   = 0;
    wbase = cfg_net_off + o * (cfg_in * cfg_k * cfg_k + 1);
    for (i = 0; i < cfg_in; i++) begin
      for (ky = 0; ky < cfg_k; ky++) begin
        for (kx = 0; kx < cfg_k; kx++) begin
          r = fy + ky - cfg_pad;
          c = fx + kx - cfg_pad;
          if (r >= 0 && c >= 0 && r < cfg_size && c < cfg_size) begin
            sum += longint'(img_model[cfg_in_off + i * cfg_size * cfg_size + r * cfg_size + c])
                 * longint'(net_model[wbase + i * cfg_k * cfg_k + ky * cfg_k + kx]);
          end
        end
      end
    end
    sum += longint'(net_model[wbase + cfg_in * cfg_k * cfg_k]);
    if (sum > 32767) begin
      return 16'h7fff;
    end else if (sum < -32768) begin
      return 16'h8000;
    end
    return data_t'(sum);
  endfunction

  // ========================================
  // checks
  // ========================================

  task automatic check_equal(input string name, input logic [15:0] exp, input logic [15:0] got);
    n_checks++;
    assert (got === exp) else begin
      $display("FAILED %s: expected %h, got %h", name, exp, got);
      n_errors++;
    end
  endtask

  task automatic check_busy_state();
    n_checks++;
    assert (core_state !== S_WAIT) else begin
      $display("FAILED core_state: expected not %h, got %h", S_WAIT, core_state);
      n_errors++;
    end
  endtask

  task automatic begin_test();
    mark_checks = n_checks;
    mark_errors = n_errors;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, n_checks - mark_checks,
             n_errors - mark_errors);
  endtask

  // ========================================
  // host side
  // ========================================

  task automatic write_img(input int addr, input data_t v);
    @(posedge clk);
    #1;
    host_net_we    = 1'b0;
    host_img_we    = 1'b1;
    host_img_addr  = addr;
    host_img_wdata = v;
    img_model[addr] = v;
  endtask

  task automatic write_net(input int addr, input data_t v);
    @(posedge clk);
    #1;
    host_img_we    = 1'b0;
    host_net_we    = 1'b1;
    host_net_addr  = addr;
    host_net_wdata = v;
    net_model[addr] = v;
  endtask

  task automatic read_img(input int addr, output data_t v);
    @(posedge clk);
    #1;
    host_raddr = addr;
    @(posedge clk);
    #1;
    v = host_rdata;
  endtask

  task automatic set_layer(input int n_in, input int n_out, input int size, input int k,
                           input int pad, input int in_off, input int out_off,
                           input int net_off);
    @(posedge clk);
    #1;
    cfg_in      = n_in;
    cfg_out     = n_out;
    cfg_size    = size;
    cfg_k       = k;
    cfg_pad     = pad;
    cfg_in_off  = in_off;
    cfg_out_off = out_off;
    cfg_net_off = net_off;
    total_in    = n_in;
    total_out   = n_out;
    img_size    = size;
    conv_size   = k;
    conv_pad    = pad;
    in_offset   = in_off;
    out_offset  = out_off;
    net_offset  = net_off;
  endtask

  // large pixels when big, with large positive weights for output 0
  // and large negative ones for output 1
  task automatic load_layer(input bit big);
    int    a;
    int    o;
    int    j;
    int    per_out;
    data_t v;
    per_out = cfg_in * cfg_k * cfg_k + 1;
    for (a = 0; a < cfg_in * cfg_size * cfg_size; a++) begin
      v = big ? large_value(1'b0) : small_value();
      write_img(cfg_in_off + a, v);
    end
    for (o = 0; o < cfg_out; o++) begin
      for (j = 0; j < per_out; j++) begin
        if (j == per_out - 1 || !big) begin
          v = small_value();
        end else begin
          v = large_value(o == 1);
        end
        write_net(cfg_net_off + o * per_out + j, v);
      end
    end
    @(posedge clk);
    #1;
    host_img_we = 1'b0;
    host_net_we = 1'b0;
  endtask

  task automatic start_layer();
    @(posedge clk);
    #1;
    req = 1'b1;
    @(posedge clk);
    #1;
    check_equal("ack", 16'h0, ack);
    check_busy_state();
    req = 1'b0;
  endtask

  // extra req edges while the layer runs
  task automatic poke_req_while_busy();
    int n;
    for (n = 0; n < 3; n++) begin
      repeat (3) @(posedge clk);
      #1;
      req = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      req = 1'b0;
      check_equal("ack", 16'h0, ack);
    end
  endtask

  task automatic wait_reset();
    int n;
    bit seen;
    seen = 1'b0;
    for (n = 0; n < 64 && !seen; n++) begin
      @(posedge clk);
      seen = xrst === 1'b1;
    end
    #1;
    if (!seen) begin
      $display("ERROR: reset was never released");
      hung = 1'b1;
    end
  endtask

  task automatic wait_ack();
    int n;
    bit seen;
    seen = 1'b0;
    for (n = 0; n < 20000 && !seen; n++) begin
      @(posedge clk);
      #1;
      seen = ack === 1'b1;
    end
    if (!seen) begin
      $display("ERROR: ack did not return");
      hung = 1'b1;
    end
  endtask

  task automatic check_layer();
    int    o;
    int    fy;
    int    fx;
    int    fea;
    int    addr;
    data_t got;
    fea = fea_size();
    for (o = 0; o < cfg_out; o++) begin
      for (fy = 0; fy < fea; fy++) begin
        for (fx = 0; fx < fea; fx++) begin
          addr = cfg_out_off + o * fea * fea + fy * fea + fx;
          read_img(addr, got);
          check_equal($sformatf("host_rdata @%h", addr[11:0]), expected_out(o, fy, fx), got);
        end
      end
    end
  endtask

  task automatic run_layer(input bit big, input bit poke);
    load_layer(big);
    start_layer();
    if (poke) begin
      poke_req_while_busy();
    end
    wait_ack();
    if (!hung) begin
      check_layer();
    end
  endtask

  // ========================================
  // test sequence
  // ========================================

  initial begin
    req            = 1'b0;
    total_in       = '0;
    total_out      = '0;
    img_size       = '0;
    conv_size      = '0;
    conv_pad       = '0;
    in_offset      = '0;
    out_offset     = '0;
    net_offset     = '0;
    host_img_we    = 1'b0;
    host_img_addr  = '0;
    host_img_wdata = '0;
    host_raddr     = '0;
    host_net_we    = 1'b0;
    host_net_addr  = '0;
    host_net_wdata = '0;
    rng_state      = 32'd42790;
    n_checks       = 0;
    n_errors       = 0;
    hung           = 1'b0;

    wait_reset();
    if (!hung) begin
      begin_test();
      check_equal("ack", 16'h1, ack);
      check_equal("core_state", S_WAIT, core_state);
      set_layer(1, 1, 4, 2, 0, 0, 256, 0);
      run_layer(1'b0, 1'b0);
      end_test("test 1 reset state and req handshake");
    end
    if (!hung) begin
      begin_test();
      set_layer(1, 1, 6, 3, 0, 0, 512, 16);
      run_layer(1'b0, 1'b0);
      end_test("test 2 6x6 image, 3x3 filter, no pad");
    end
    if (!hung) begin
      begin_test();
      set_layer(1, 1, 5, 3, 1, 64, 600, 32);
      run_layer(1'b0, 1'b0);
      end_test("test 3 5x5 image, pad 1");
    end
    if (!hung) begin
      begin_test();
      set_layer(3, 2, 6, 3, 1, 1024, 1536, 64);
      run_layer(1'b0, 1'b0);
      end_test("test 4 three inputs, two outputs");
    end
    if (!hung) begin
      begin_test();
      set_layer(1, 2, 4, 3, 0, 2048, 2304, 160);
      run_layer(1'b1, 1'b0);
      end_test("test 5 saturation");
    end
    if (!hung) begin
      begin_test();
      set_layer(1, 1, 5, 3, 0, 2560, 2688, 300);
      run_layer(1'b0, 1'b1);
      if (!hung) begin
        // no hidden restart from the edges seen while busy
        repeat (20) @(posedge clk);
        #1;
        check_equal("ack", 16'h1, ack);
        check_equal("core_state", S_WAIT, core_state);
        set_layer(2, 1, 4, 3, 1, 2816, 3072, 400);
        run_layer(1'b0, 1'b0);
      end
      end_test("test 6 req while busy, then new layer");
    end

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0 && !hung) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
